//--- Makefile
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := files.f
VFLAGS    := --timing -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
verilog/bk_pkg.sv
verilog/mul_unit.sv
verilog/lsu_axil.sv
verilog/data_buff.sv
verilog/wb_stage.sv
verilog/exu_backend_top.sv
verif/axil_mem_model.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- verif/axil_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model (
  input  logic              clk,
  input  logic              rst,
  input  bk_pkg::axil_req_t axi_i,
  output bk_pkg::axil_rsp_t axi_o,
  output int                fence_writes_o,
  output int                bad_writes_o
);

  localparam logic [bk_pkg::XLEN-1:0] RD_MASK = 32'h5a5a_a5a5;

  int unsigned               ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic                      r_pend, aw_got, w_got;
  logic [bk_pkg::XLEN-1:0]   raddr, waddr, wdata;
  logic [bk_pkg::STRB_W-1:0] wstrb;
  bk_pkg::axil_rsp_t         rsp;  // response state, seen by the master half a cycle later

  always @(posedge clk) begin
    if (rst) begin
      rsp            <= '0;
      r_pend         <= 1'b0;
      aw_got         <= 1'b0;
      w_got          <= 1'b0;
      ar_wait        <= $urandom_range(5, 0);
      r_wait         <= $urandom_range(5, 0);
      aw_wait        <= $urandom_range(5, 0);
      w_wait         <= $urandom_range(5, 0);
      b_wait         <= $urandom_range(5, 0);
      fence_writes_o <= 0;
      bad_writes_o   <= 0;
    end else begin
      rsp.arready <= 1'b0;  // ready pulses last one cycle
      rsp.awready <= 1'b0;
      rsp.wready  <= 1'b0;

      if (axi_i.arvalid && !rsp.arready && !r_pend) begin
        if (ar_wait == 0) begin
          rsp.arready <= 1'b1;
          raddr       <= axi_i.araddr;
          r_pend      <= 1'b1;
          ar_wait     <= $urandom_range(5, 0);
        end else ar_wait <= ar_wait - 1;
      end
      if (r_pend && !rsp.arready && !rsp.rvalid) begin
        if (r_wait == 0) begin
          rsp.rvalid <= 1'b1;
          rsp.rdata  <= raddr ^ RD_MASK;  // data follows the whole address
          r_wait     <= $urandom_range(5, 0);
        end else r_wait <= r_wait - 1;
      end
      if (rsp.rvalid && axi_i.rready) begin
        rsp.rvalid <= 1'b0;
        r_pend     <= 1'b0;
      end

      if (axi_i.awvalid && !aw_got) begin
        if (aw_wait == 0) begin
          rsp.awready <= 1'b1;
          waddr       <= axi_i.awaddr;
          aw_got      <= 1'b1;
          aw_wait     <= $urandom_range(5, 0);
        end else aw_wait <= aw_wait - 1;
      end
      if (axi_i.wvalid && !w_got) begin
        if (w_wait == 0) begin
          rsp.wready <= 1'b1;
          wdata      <= axi_i.wdata;
          wstrb      <= axi_i.wstrb;
          w_got      <= 1'b1;
          w_wait     <= $urandom_range(5, 0);
        end else w_wait <= w_wait - 1;
      end
      if (aw_got && w_got && !rsp.awready && !rsp.wready && !rsp.bvalid) begin
        if (b_wait == 0) begin
          rsp.bvalid <= 1'b1;
          b_wait     <= $urandom_range(5, 0);
          if (waddr == bk_pkg::FENCE_ADDR && wdata == bk_pkg::FENCE_DATA && &wstrb)
            fence_writes_o <= fence_writes_o + 1;
          else
            bad_writes_o <= bad_writes_o + 1;  // anything else is unexpected
        end else b_wait <= b_wait - 1;
      end
      if (rsp.bvalid && axi_i.bready) begin
        rsp.bvalid <= 1'b0;
        aw_got     <= 1'b0;
        w_got      <= 1'b0;
      end
    end
  end

  // responses reach the master on the falling edge
  initial begin
    axi_o = '0;
    forever begin
      @(negedge clk);
      axi_o <= rsp;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush_i,
  input  logic              issue_valid_i,
  input  logic              issue_ready_i,
  input  bk_pkg::issue_t    issue_i,
  input  logic              result_valid_i,
  input  logic              result_ready_i,
  input  bk_pkg::result_t   result_i,
  input  bk_pkg::axil_req_t axi_i,
  input  logic              end_i,
  input  int                fence_writes_i,
  input  int                bad_writes_i,
  output int                mismatches_o,
  output int                failures_o,
  output int                pending_o
);

  localparam logic [bk_pkg::XLEN-1:0] RD_MASK = 32'h5a5a_a5a5;

  bk_pkg::result_t expq [$];  // predicted results in issue order
  bk_pkg::result_t held;
  logic            held_q = 1'b0;
  logic            started = 1'b0;
  logic            seen_issue = 1'b0;
  logic            ended = 1'b0;
  int              fences_issued = 0;
  int              mism = 0;
  int              fails = 0;

  function automatic bk_pkg::result_t predict_result(input bk_pkg::issue_t op);
    logic [2*bk_pkg::XLEN-1:0] prod;
    bk_pkg::result_t           r;
    prod   = {32'h0, op.a} * {32'h0, op.b};
    r.tag  = op.tag;
    r.op   = op.op;
    case (op.op)
      bk_pkg::OP_MUL:   r.data = prod[bk_pkg::XLEN-1:0];
      bk_pkg::OP_MULHU: r.data = prod[2*bk_pkg::XLEN-1:bk_pkg::XLEN];
      bk_pkg::OP_LOAD:  r.data = op.a ^ RD_MASK;
      default:          r.data = '0;  // fence.i
    endcase
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      mism++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic report_failure(input string msg);
    fails++;
    $display("error at %0t: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    bk_pkg::result_t want;
    if (rst) begin
      if (started && issue_ready_i !== 1'b0) report_failure("issue_ready_o high during reset");
      if (started && result_valid_i !== 1'b0) report_failure("result_valid_o high during reset");
      started = 1'b1;  // registers hold reset values from the second edge on
      held_q  = 1'b0;
    end else begin
      if (result_valid_i && result_ready_i) begin
        if (expq.size() == 0) begin
          report_failure($sformatf("result with tag %0d was not expected", result_i.tag));
        end else begin
          want = expq.pop_front();
          compare_value("result_o.tag", 64'(result_i.tag), 64'(want.tag));
          compare_value("result_o.op", 64'(result_i.op), 64'(want.op));
          compare_value("result_o.data", 64'(result_i.data), 64'(want.data));
        end
      end
      if (held_q && result_valid_i !== 1'b1)
        report_failure("result_valid_o dropped before result_ready_i was seen");
      else if (held_q)
        compare_value("result_o under back-pressure", 64'(result_i), 64'(held));
      held_q = result_valid_i && !result_ready_i && !flush_i;
      held   = result_i;
      if (flush_i) expq.delete();  // every op in flight is discarded
      if (!seen_issue && (result_valid_i || axi_i.arvalid || axi_i.awvalid || axi_i.wvalid ||
                          axi_i.rready || axi_i.bready))
        report_failure("a valid or ready output was high before the first issue");
      if (issue_valid_i && issue_ready_i) begin
        expq.push_back(predict_result(issue_i));
        seen_issue = 1'b1;
        if (issue_i.op == bk_pkg::OP_FENCEI) fences_issued++;
      end
    end
    if (end_i && !ended) begin
      ended = 1'b1;
      if (expq.size() != 0)
        report_failure($sformatf("%0d issued ops never returned a result", expq.size()));
      if (fence_writes_i != fences_issued)
        report_failure($sformatf("memory saw %0d invalidate writes for %0d fence.i ops",
                                 fence_writes_i, fences_issued));
      if (bad_writes_i != 0)
        report_failure($sformatf("memory saw %0d writes with wrong address or data",
                                 bad_writes_i));
    end
    mismatches_o = mism;
    failures_o   = fails;
    pending_o    = expq.size();
  end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int NROWS      = 18;
  localparam int WAIT_LIMIT = 1000;  // cycles per wait

  typedef struct packed {
    bk_pkg::op_e             op;
    logic [bk_pkg::XLEN-1:0] a;
    logic [bk_pkg::XLEN-1:0] b;
    logic [7:0]              hold;   // forced back-pressure cycles after issue
    logic                    flush;  // flush right after issue
  } row_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              flush;
  logic              issue_valid;
  bk_pkg::issue_t    issue;
  logic              issue_ready;
  logic              result_valid;
  bk_pkg::result_t   result;
  logic              result_ready = 1'b0;
  bk_pkg::axil_req_t axi_req;
  bk_pkg::axil_rsp_t axi_rsp;
  logic              end_checks;
  int                fence_writes, bad_writes;
  int                mismatches, failures, pending;
  int                timeouts;
  int unsigned       cyc = 0;
  int unsigned       hold_until = 0;
  row_t              tbl [NROWS];

  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // consumer side is held low after some issues and random otherwise
  always @(negedge clk) begin
    if (rst) result_ready = 1'b0;
    else if (cyc < hold_until) result_ready = 1'b0;
    else result_ready = ($urandom_range(3, 0) != 0);
  end

  exu_backend_top DUT (
    .clk(clk), .rst(rst), .flush_i(flush),
    .issue_valid_i(issue_valid), .issue_i(issue), .issue_ready_o(issue_ready),
    .result_valid_o(result_valid), .result_o(result), .result_ready_i(result_ready),
    .m_axi_o(axi_req), .m_axi_i(axi_rsp)
  );

  axil_mem_model u_mem (
    .clk(clk), .rst(rst), .axi_i(axi_req), .axi_o(axi_rsp),
    .fence_writes_o(fence_writes), .bad_writes_o(bad_writes)
  );

  tb_checker u_chk (
    .clk(clk), .rst(rst), .flush_i(flush),
    .issue_valid_i(issue_valid), .issue_ready_i(issue_ready), .issue_i(issue),
    .result_valid_i(result_valid), .result_ready_i(result_ready), .result_i(result),
    .axi_i(axi_req), .end_i(end_checks),
    .fence_writes_i(fence_writes), .bad_writes_i(bad_writes),
    .mismatches_o(mismatches), .failures_o(failures), .pending_o(pending)
  );

  task automatic load_table();
    tbl[0]  = '{bk_pkg::OP_MUL,    32'h0000_0003, 32'h0000_0005, 8'd0,  1'b0};
    tbl[1]  = '{bk_pkg::OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 8'd0,  1'b0};
    tbl[2]  = '{bk_pkg::OP_MUL,    32'hffff_ffff, 32'hffff_ffff, 8'd80, 1'b0};
    tbl[3]  = '{bk_pkg::OP_LOAD,   32'h0000_0100, 32'h0000_0000, 8'd0,  1'b0};
    tbl[4]  = '{bk_pkg::OP_MULHU,  32'h0000_0000, 32'hffff_ffff, 8'd0,  1'b0};
    tbl[5]  = '{bk_pkg::OP_FENCEI, 32'h0000_0000, 32'h0000_0000, 8'd0,  1'b0};
    tbl[6]  = '{bk_pkg::OP_LOAD,   32'h0000_2000, 32'h0000_0000, 8'd60, 1'b0};
    tbl[7]  = '{bk_pkg::OP_MUL,    32'h1234_5678, 32'h9abc_def0, 8'd0,  1'b0};
    tbl[8]  = '{bk_pkg::OP_MUL,    32'hdead_beef, 32'h0000_0003, 8'd0,  1'b1};
    tbl[9]  = '{bk_pkg::OP_LOAD,   32'h0000_0040, 32'h0000_0000, 8'd0,  1'b0};
    tbl[10] = '{bk_pkg::OP_LOAD,   32'h0000_3000, 32'h0000_0000, 8'd0,  1'b1};
    tbl[11] = '{bk_pkg::OP_MULHU,  32'h8000_0000, 32'h0000_0004, 8'd0,  1'b0};
    tbl[12] = '{bk_pkg::OP_FENCEI, 32'h0000_0000, 32'h0000_0000, 8'd70, 1'b0};
    tbl[13] = '{bk_pkg::OP_MULHU,  32'h1234_5678, 32'h9abc_def0, 8'd0,  1'b0};
    tbl[14] = '{bk_pkg::OP_FENCEI, 32'h0000_0000, 32'h0000_0000, 8'd0,  1'b1};
    tbl[15] = '{bk_pkg::OP_LOAD,   32'hffff_fffc, 32'h0000_0000, 8'd50, 1'b0};
    tbl[16] = '{bk_pkg::OP_FENCEI, 32'h0000_0000, 32'h0000_0000, 8'd0,  1'b0};
    tbl[17] = '{bk_pkg::OP_MUL,    32'h8765_4321, 32'h0000_0000, 8'd0,  1'b0};
  endtask

  // called and returns on a falling edge
  task automatic wait_issue_ready(output bit expired);
    int n;
    n = 0;
    while (issue_ready !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expired = (issue_ready !== 1'b1);
    if (expired) begin
      timeouts++;
      $display("timeout at %0t: issue_ready_o did not rise", $time);
    end
  endtask

  task automatic wait_drained(output bit expired);
    int n;
    n = 0;
    while ((pending != 0 || issue_ready !== 1'b1) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expired = (pending != 0 || issue_ready !== 1'b1);
    if (expired) begin
      timeouts++;
      $display("timeout at %0t: %0d results still outstanding", $time, pending);
    end
  endtask

  initial begin
    bit timed_out;
    timed_out   = 1'b0;
    timeouts    = 0;
    void'($urandom(32'hfb36_5e9d));
    rst         = 1'b1;
    flush       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    end_checks  = 1'b0;
    load_table();
    repeat (10) @(negedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NROWS && !timed_out; i++) begin
      wait_issue_ready(timed_out);
      if (!timed_out) begin
        issue_valid = 1'b1;
        issue       = '{op: tbl[i].op, a: tbl[i].a, b: tbl[i].b, tag: 4'(i)};
        hold_until <= cyc + 32'(tbl[i].hold);
        @(negedge clk);
        issue_valid = 1'b0;
        if (tbl[i].flush) begin
          flush = 1'b1;  // op is still inside a unit here
          @(negedge clk);
          flush = 1'b0;
        end
      end
    end
    if (!timed_out) wait_drained(timed_out);
    end_checks = 1'b1;
    repeat (2) @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
             mismatches, failures, timeouts);
    if (mismatches == 0 && failures == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bk_pkg.sv
`default_nettype none

package bk_pkg;

  localparam int XLEN   = 32;
  localparam int TAG_W  = 4;
  localparam int STRB_W = XLEN / 8;

  // per-stage stall vector, only two bits are driven
  localparam int CTRL_W      = 6;
  localparam int CTRL_ID_EX  = 1;
  localparam int CTRL_EX_MEM = 2;

  // icache invalidate register
  localparam logic [XLEN-1:0] FENCE_ADDR = 32'h0000_1000;
  localparam logic [XLEN-1:0] FENCE_DATA = 32'h0000_0001;

  // stall buffer entry slots
  localparam int BUF_ALU    = 0;
  localparam int BUF_RDATA  = 1;
  localparam int BUF_FENCE  = 2;
  localparam int BUF_N      = 3;
  localparam int BUF_DATA_N = 2;  // fence entry carries no data

  typedef enum logic [1:0] {
    OP_MUL    = 2'd0,
    OP_MULHU  = 2'd1,
    OP_LOAD   = 2'd2,
    OP_FENCEI = 2'd3
  } op_e;

  typedef struct packed {
    op_e              op;
    logic [XLEN-1:0]  a;    // multiplicand or load address
    logic [XLEN-1:0]  b;    // multiplier
    logic [TAG_W-1:0] tag;
  } issue_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    op_e              op;
    logic [XLEN-1:0]  data;
  } result_t;

  typedef struct packed {
    logic              arvalid;
    logic [XLEN-1:0]   araddr;
    logic              rready;
    logic              awvalid;
    logic [XLEN-1:0]   awaddr;
    logic              wvalid;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bready;
  } axil_req_t;

  typedef struct packed {
    logic            arready;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            awready;
    logic            wready;
    logic            bvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- verilog/data_buff.sv
`timescale 1ns/1ps
`default_nettype none

module data_buff (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush_i,
  input  logic [bk_pkg::CTRL_W-1:0] stall_i,

  input  logic                      alu_data_ready_i,
  input  logic [bk_pkg::XLEN-1:0]   alu_data_i,
  output logic                      alu_buff_valid_o,
  output logic [bk_pkg::XLEN-1:0]   alu_buff_o,

  input  logic                      mem_data_ready_i,
  input  logic [bk_pkg::XLEN-1:0]   mem_data_i,
  output logic                      rdata_buff_valid_o,
  output logic [bk_pkg::XLEN-1:0]   rdata_buff_o,

  input  logic                      fencei_ready_i,
  output logic                      fencei_buff_valid_o
);

  logic [bk_pkg::BUF_N-1:0] pulse;    // unit result strobes
  logic [bk_pkg::BUF_N-1:0] hold;     // owning stage stalled
  logic [bk_pkg::BUF_N-1:0] valid_q;
  logic [bk_pkg::XLEN-1:0]  din    [bk_pkg::BUF_DATA_N];
  logic [bk_pkg::XLEN-1:0]  data_q [bk_pkg::BUF_DATA_N];

  assign pulse[bk_pkg::BUF_ALU]   = alu_data_ready_i;
  assign pulse[bk_pkg::BUF_RDATA] = mem_data_ready_i;
  assign pulse[bk_pkg::BUF_FENCE] = fencei_ready_i;

  // multiplier sits under id_ex, memory results under ex_mem
  assign hold[bk_pkg::BUF_ALU]   = stall_i[bk_pkg::CTRL_ID_EX];
  assign hold[bk_pkg::BUF_RDATA] = stall_i[bk_pkg::CTRL_EX_MEM];
  assign hold[bk_pkg::BUF_FENCE] = stall_i[bk_pkg::CTRL_EX_MEM];

  assign din[bk_pkg::BUF_ALU]   = alu_data_i;
  assign din[bk_pkg::BUF_RDATA] = mem_data_i;

  // same capture / release rule for every entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < bk_pkg::BUF_N; i++) begin
      if (rst || flush_i) begin
        valid_q[i] <= 1'b0;
      end else if (pulse[i] && hold[i]) begin
        valid_q[i] <= 1'b1;  // result arrived while stalled
      end else if (valid_q[i] && !hold[i]) begin
        valid_q[i] <= 1'b0;  // writeback takes it this edge
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < bk_pkg::BUF_DATA_N; i++) begin
      if (pulse[i] && hold[i]) data_q[i] <= din[i];
    end
  end

  assign alu_buff_valid_o    = valid_q[bk_pkg::BUF_ALU];
  assign alu_buff_o          = data_q[bk_pkg::BUF_ALU];
  assign rdata_buff_valid_o  = valid_q[bk_pkg::BUF_RDATA];
  assign rdata_buff_o        = data_q[bk_pkg::BUF_RDATA];
  assign fencei_buff_valid_o = valid_q[bk_pkg::BUF_FENCE];

endmodule

`default_nettype wire

//--- verilog/exu_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_backend_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush_i,
  input  logic              issue_valid_i,
  input  bk_pkg::issue_t    issue_i,
  output logic              issue_ready_o,
  output logic              result_valid_o,
  output bk_pkg::result_t   result_o,
  input  logic              result_ready_i,
  output bk_pkg::axil_req_t m_axi_o,
  input  bk_pkg::axil_rsp_t m_axi_i
);

  logic                      run_q;  // low until reset is released
  logic                      issue_fire;
  logic                      is_mul;
  logic                      mul_busy, mul_ready;
  logic                      lsu_busy, load_ready, fencei_ready;
  logic [bk_pkg::XLEN-1:0]   mul_data, load_data;
  logic                      alu_bv, rdata_bv, fencei_bv;
  logic [bk_pkg::XLEN-1:0]   alu_buff, rdata_buff;
  logic [bk_pkg::CTRL_W-1:0] stall;
  logic [bk_pkg::TAG_W-1:0]  tag_q;
  bk_pkg::op_e               op_q;

  always_ff @(posedge clk) begin
    if (rst) run_q <= 1'b0;
    else     run_q <= 1'b1;
  end

  // one op at a time, and nothing parked in the buffer
  assign issue_ready_o = run_q && !mul_busy && !lsu_busy && !alu_bv && !rdata_bv
                         && !fencei_bv && !flush_i;
  assign issue_fire = issue_valid_i && issue_ready_o;
  assign is_mul     = (issue_i.op == bk_pkg::OP_MUL) || (issue_i.op == bk_pkg::OP_MULHU);

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      tag_q <= issue_i.tag;  // identity of the op in flight
      op_q  <= issue_i.op;
    end
  end

  mul_unit u_mul (
    .clk(clk), .rst(rst), .flush_i(flush_i),
    .start_i(issue_fire && is_mul), .hi_i(issue_i.op == bk_pkg::OP_MULHU),
    .a_i(issue_i.a), .b_i(issue_i.b),
    .busy_o(mul_busy), .ready_o(mul_ready), .data_o(mul_data)
  );

  lsu_axil u_lsu (
    .clk(clk), .rst(rst), .flush_i(flush_i),
    .start_i(issue_fire && !is_mul), .op_i(issue_i.op), .addr_i(issue_i.a),
    .axi_o(m_axi_o), .axi_i(m_axi_i), .busy_o(lsu_busy),
    .load_ready_o(load_ready), .load_data_o(load_data), .fencei_ready_o(fencei_ready)
  );

  data_buff u_buff (
    .clk(clk), .rst(rst), .flush_i(flush_i), .stall_i(stall),
    .alu_data_ready_i(mul_ready), .alu_data_i(mul_data),
    .alu_buff_valid_o(alu_bv), .alu_buff_o(alu_buff),
    .mem_data_ready_i(load_ready), .mem_data_i(load_data),
    .rdata_buff_valid_o(rdata_bv), .rdata_buff_o(rdata_buff),
    .fencei_ready_i(fencei_ready), .fencei_buff_valid_o(fencei_bv)
  );

  wb_stage u_wb (
    .clk(clk), .rst(rst), .flush_i(flush_i), .tag_i(tag_q), .op_i(op_q),
    .mul_ready_i(mul_ready), .mul_data_i(mul_data),
    .load_ready_i(load_ready), .load_data_i(load_data), .fencei_ready_i(fencei_ready),
    .alu_buff_valid_i(alu_bv), .alu_buff_i(alu_buff),
    .rdata_buff_valid_i(rdata_bv), .rdata_buff_i(rdata_buff),
    .fencei_buff_valid_i(fencei_bv),
    .result_valid_o(result_valid_o), .result_o(result_o),
    .result_ready_i(result_ready_i), .stall_o(stall)
  );

endmodule

`default_nettype wire

//--- verilog/lsu_axil.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_axil (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    start_i,
  input  bk_pkg::op_e             op_i,
  input  logic [bk_pkg::XLEN-1:0] addr_i,
  output bk_pkg::axil_req_t       axi_o,
  input  bk_pkg::axil_rsp_t       axi_i,
  output logic                    busy_o,
  output logic                    load_ready_o,
  output logic [bk_pkg::XLEN-1:0] load_data_o,
  output logic                    fencei_ready_o
);

  typedef enum logic [2:0] {
    LSU_IDLE,
    LSU_AR,   // read address out
    LSU_R,    // waiting for read data
    LSU_WR,   // aw and w in flight
    LSU_B     // waiting for write response
  } lsu_state_e;

  lsu_state_e              state_q;
  logic [bk_pkg::XLEN-1:0] addr_q;
  logic                    aw_pend_q;
  logic                    w_pend_q;
  logic                    drop_q;  // flushed, finish bus side quietly
  logic                    load_ready_q;
  logic                    fencei_ready_q;
  logic [bk_pkg::XLEN-1:0] load_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= LSU_IDLE;
      aw_pend_q      <= 1'b0;
      w_pend_q       <= 1'b0;
      drop_q         <= 1'b0;
      load_ready_q   <= 1'b0;
      fencei_ready_q <= 1'b0;
    end else begin
      load_ready_q   <= 1'b0;
      fencei_ready_q <= 1'b0;
      if (flush_i && state_q != LSU_IDLE) drop_q <= 1'b1;
      case (state_q)
        LSU_IDLE: begin
          if (start_i) begin
            drop_q <= 1'b0;
            if (op_i == bk_pkg::OP_LOAD) begin
              state_q <= LSU_AR;
            end else if (op_i == bk_pkg::OP_FENCEI) begin
              state_q   <= LSU_WR;
              aw_pend_q <= 1'b1;
              w_pend_q  <= 1'b1;
            end
          end
        end
        LSU_AR: begin
          if (axi_i.arready) state_q <= LSU_R;
        end
        LSU_R: begin
          if (axi_i.rvalid) begin
            state_q      <= LSU_IDLE;
            load_ready_q <= !(drop_q || flush_i);
          end
        end
        LSU_WR: begin
          if (aw_pend_q && axi_i.awready) aw_pend_q <= 1'b0;
          if (w_pend_q && axi_i.wready) w_pend_q <= 1'b0;
          if ((!aw_pend_q || axi_i.awready) && (!w_pend_q || axi_i.wready)) begin
            state_q <= LSU_B;  // both channels accepted
          end
        end
        LSU_B: begin
          if (axi_i.bvalid) begin
            state_q        <= LSU_IDLE;
            fencei_ready_q <= !(drop_q || flush_i);
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == LSU_IDLE && start_i) addr_q <= addr_i;
    if (state_q == LSU_R && axi_i.rvalid) load_data_q <= axi_i.rdata;
  end

  always_comb begin
    axi_o         = '0;
    axi_o.arvalid = (state_q == LSU_AR);
    axi_o.araddr  = addr_q;
    axi_o.rready  = (state_q == LSU_R);
    axi_o.awvalid = (state_q == LSU_WR) && aw_pend_q;
    axi_o.awaddr  = bk_pkg::FENCE_ADDR;
    axi_o.wvalid  = (state_q == LSU_WR) && w_pend_q;
    axi_o.wdata   = bk_pkg::FENCE_DATA;
    axi_o.wstrb   = '1;
    axi_o.bready  = (state_q == LSU_B);
  end

  assign busy_o         = (state_q != LSU_IDLE) || load_ready_q || fencei_ready_q;
  assign load_ready_o   = load_ready_q;
  assign load_data_o    = load_data_q;
  assign fencei_ready_o = fencei_ready_q;

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    start_i,
  input  logic                    hi_i,
  input  logic [bk_pkg::XLEN-1:0] a_i,
  input  logic [bk_pkg::XLEN-1:0] b_i,
  output logic                    busy_o,
  output logic                    ready_o,
  output logic [bk_pkg::XLEN-1:0] data_o
);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_OUT
  } mul_state_e;

  mul_state_e                            state_q;
  logic [$clog2(bk_pkg::XLEN)-1:0]       cnt_q;
  logic [2*bk_pkg::XLEN-1:0]             acc_q;  // {partial high, remaining multiplier}
  logic [bk_pkg::XLEN-1:0]               a_q;
  logic                                  hi_q;
  logic                                  ready_q;
  logic [bk_pkg::XLEN-1:0]               data_q;
  logic [bk_pkg::XLEN:0]                 sum;    // carry kept for the shift

  assign sum = {1'b0, acc_q[2*bk_pkg::XLEN-1:bk_pkg::XLEN]} + {1'b0, a_q};

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      state_q <= MUL_IDLE;  // flush drops the op, no pulse
      cnt_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        MUL_IDLE: begin
          if (start_i) begin
            state_q <= MUL_RUN;
            cnt_q   <= '0;
          end
        end
        MUL_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (&cnt_q) state_q <= MUL_OUT;  // 32nd step done
        end
        MUL_OUT: begin
          ready_q <= 1'b1;
          state_q <= MUL_IDLE;
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE && start_i) begin
      a_q   <= a_i;
      acc_q <= {{bk_pkg::XLEN{1'b0}}, b_i};
      hi_q  <= hi_i;
    end else if (state_q == MUL_RUN) begin
      acc_q <= acc_q[0] ? {sum, acc_q[bk_pkg::XLEN-1:1]} : {1'b0, acc_q[2*bk_pkg::XLEN-1:1]};
    end
    if (state_q == MUL_OUT) begin
      data_q <= hi_q ? acc_q[2*bk_pkg::XLEN-1:bk_pkg::XLEN] : acc_q[bk_pkg::XLEN-1:0];
    end
  end

  // busy until the pulse is gone so no second op slips in beside it
  assign busy_o  = (state_q != MUL_IDLE) || ready_q;
  assign ready_o = ready_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- verilog/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush_i,
  input  logic [bk_pkg::TAG_W-1:0]   tag_i,
  input  bk_pkg::op_e                op_i,

  input  logic                       mul_ready_i,
  input  logic [bk_pkg::XLEN-1:0]    mul_data_i,
  input  logic                       load_ready_i,
  input  logic [bk_pkg::XLEN-1:0]    load_data_i,
  input  logic                       fencei_ready_i,

  input  logic                       alu_buff_valid_i,
  input  logic [bk_pkg::XLEN-1:0]    alu_buff_i,
  input  logic                       rdata_buff_valid_i,
  input  logic [bk_pkg::XLEN-1:0]    rdata_buff_i,
  input  logic                       fencei_buff_valid_i,

  output logic                       result_valid_o,
  output bk_pkg::result_t            result_o,
  input  logic                       result_ready_i,
  output logic [bk_pkg::CTRL_W-1:0]  stall_o
);

  logic                    valid_q;
  bk_pkg::result_t         result_q;
  logic                    stall;     // holding a result nobody took
  logic                    sel_hit;
  logic [bk_pkg::XLEN-1:0] sel_data;

  assign stall = valid_q && !result_ready_i;

  // both stall bits equal stall, so one check covers live and buffered sources
  always_comb begin
    sel_hit  = 1'b1;
    sel_data = '0;
    if (mul_ready_i) begin
      sel_data = mul_data_i;
    end else if (load_ready_i) begin
      sel_data = load_data_i;
    end else if (fencei_ready_i) begin
      sel_data = '0;  // fence.i returns zero
    end else if (alu_buff_valid_i) begin
      sel_data = alu_buff_i;
    end else if (rdata_buff_valid_i) begin
      sel_data = rdata_buff_i;
    end else if (fencei_buff_valid_i) begin
      sel_data = '0;
    end else begin
      sel_hit = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= 1'b0;
    end else if (sel_hit && !stall) begin
      valid_q <= 1'b1;
    end else if (result_ready_i) begin
      valid_q <= 1'b0;  // consumed, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (sel_hit && !stall) result_q <= '{tag: tag_i, op: op_i, data: sel_data};
  end

  always_comb begin
    stall_o                      = '0;
    stall_o[bk_pkg::CTRL_ID_EX]  = stall;
    stall_o[bk_pkg::CTRL_EX_MEM] = stall;
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;

endmodule

`default_nettype wire
